// ==== src/sv32_cfg_pkg.sv ====
// Sv32 geometry constants for the page-table walker.
// Imported by the type package and by every walker module that
// needs address, page-number or level widths.

package sv32_cfg_pkg;

  // ----------------------------------------
  // address widths
  // ----------------------------------------
  // virtual address, one XLEN word
  localparam int unsigned VLEN = 32;
  // physical address, 22-bit ppn plus page offset
  localparam int unsigned PLEN = 34;
  // data word returned by the memory port
  localparam int unsigned XLEN = 32;

  // ----------------------------------------
  // paging structure
  // ----------------------------------------
  // full physical page number
  localparam int unsigned PPNW = 22;
  // one vpn slice indexes 1024 entries
  localparam int unsigned VPN_W = 10;
  // root table and leaf table
  localparam int unsigned PT_LEVELS = 2;
  localparam int unsigned LVL_W = $clog2(PT_LEVELS);
  // 4 KiB pages
  localparam int unsigned PAGE_OFFSET_W = 12;
  // 4-byte entries
  localparam int unsigned PTE_BYTES_LOG2 = 2;
  // Sv32 satp holds at most 9 ASID bits
  localparam int unsigned ASID_MAX_W = 9;

endpackage

// ==== src/sv32_types_pkg.sv ====
// Shared types of the Sv32 walker: the page-table entry word, the
// memory port, the miss request, the walk context and the TLB update.

package sv32_types_pkg;

  import sv32_cfg_pkg::*;

  // ----------------------------------------
  // page-table entry
  // ----------------------------------------
  // permission and status bits, same place in both views
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_flags_t;

  // leaf view, ppn split so the superpage alignment check sees ppn0
  typedef struct packed {
    logic [PPNW-VPN_W-1:0] ppn1;
    logic [VPN_W-1:0]      ppn0;
    logic [1:0]            rsw;
    pte_flags_t            flags;
  } pte_leaf_t;

  // pointer view, one full ppn of the next table
  typedef struct packed {
    logic [PPNW-1:0] ppn;
    logic [1:0]      rsw;
    pte_flags_t      flags;
  } pte_ptr_t;

  typedef union packed {
    pte_leaf_t leaf;
    pte_ptr_t  ptr;
  } pte_u;

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  typedef struct packed {
    logic            req;
    logic [PLEN-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

  // ----------------------------------------
  // walk control and result
  // ----------------------------------------
  typedef struct packed {
    logic            access;
    logic            hit;
    logic            is_instr;
    logic            is_store;
    logic [VLEN-1:0] vaddr;
  } miss_req_t;

  // asid is sized for the largest Sv32 ASID, low AsidWidth bits used
  typedef struct packed {
    logic                  is_instr;
    logic                  is_store;
    logic [LVL_W-1:0]      level;
    logic                  is_global;
    logic [ASID_MAX_W-1:0] asid;
  } ptw_ctx_t;

  typedef struct packed {
    logic                          valid;
    logic                          is_superpage;
    logic [VLEN-PAGE_OFFSET_W-1:0] vpn;
    logic [ASID_MAX_W-1:0]         asid;
    pte_u                          content;
  } tlb_update_t;

  typedef struct packed {
    logic            fault;
    logic            leaf;
    logic [PPNW-1:0] next_ppn;
  } pte_class_t;

endpackage

// ==== src/pte_decode.sv ====
// Combinational classification of one fetched Sv32 entry.
// Flags invalid encodings, pointers past the last level, misaligned
// superpages and permission failures for the access being walked.
`timescale 1ns/100ps

module pte_decode (
  input  sv32_types_pkg::pte_u       pte_i,
  input  sv32_types_pkg::ptw_ctx_t   ctx_i,
  input  logic                       mxr_i,
  output sv32_types_pkg::pte_class_t cls_o
);

  import sv32_cfg_pkg::*;
  import sv32_types_pkg::*;

  pte_flags_t flags;
  logic       invalid;
  logic       is_leaf;
  logic       bad_ptr;
  logic       misaligned;
  logic       perm_ok;

  assign flags = pte_i.leaf.flags;

  // ----------------------------------------
  // structure checks
  // ----------------------------------------
  // v clear or write-only encoding
  assign invalid = !flags.v || (flags.w && !flags.r);

  // r or x marks a leaf, otherwise it points to the next table
  assign is_leaf = flags.r || flags.x;

  // no table below the last level
  assign bad_ptr = !is_leaf && (ctx_i.level == LVL_W'(PT_LEVELS - 1));

  // a 4 MiB superpage needs its low ppn slice clear
  assign misaligned = is_leaf && (ctx_i.level == '0) && (pte_i.leaf.ppn0 != '0);

  // ----------------------------------------
  // permission checks
  // ----------------------------------------
  always_comb begin
    if (ctx_i.is_instr) begin
      // fetch needs execute, accessed bit is managed by software
      perm_ok = flags.x && flags.a;
    end else begin
      // load needs r, or x when make-executable-readable is set
      perm_ok = flags.a && (flags.r || (flags.x && mxr_i));
      // stores also need w and an already set dirty bit
      if (ctx_i.is_store) begin
        perm_ok = perm_ok && flags.w && flags.d;
      end
    end
  end

  assign cls_o.fault    = invalid || bad_ptr || misaligned || (is_leaf && !perm_ok);
  assign cls_o.leaf     = is_leaf;
  assign cls_o.next_ppn = pte_i.ptr.ppn;

endmodule

// ==== src/walk_fsm.sv ====
// Walk control of the Sv32 walker. Accepts a TLB miss, fetches one
// entry per level over the memory port, follows pointers and reports
// a finished leaf (done) or a page fault. Flush drains an open read.
`timescale 1ns/100ps

module walk_fsm #(
  parameter int unsigned AsidWidth = 9
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  sv32_types_pkg::miss_req_t     miss_i,
  input  logic [sv32_cfg_pkg::PPNW-1:0] satp_ppn_i,
  input  logic [AsidWidth-1:0]          asid_i,
  input  sv32_types_pkg::mem_rsp_t      mem_rsp_i,
  output sv32_types_pkg::mem_req_t      mem_req_o,
  input  sv32_types_pkg::pte_class_t    cls_i,
  output sv32_types_pkg::pte_u          pte_o,
  output sv32_types_pkg::ptw_ctx_t      ctx_o,
  output logic [sv32_cfg_pkg::VLEN-1:0] vaddr_o,
  output logic                          done_o,
  output logic                          fault_o,
  output logic                          active_o,
  output logic                          miss_o
);

  import sv32_cfg_pkg::*;
  import sv32_types_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    WAIT_RVALID,
    PROPAGATE_ERROR,
    LATENCY
  } state_e;

  state_e           state_q, state_d;
  ptw_ctx_t         ctx_q, ctx_d;
  logic [VLEN-1:0]  vaddr_q, vaddr_d;
  // entry pointer, 4-byte aligned
  logic [PLEN-1:0]  pptr_q, pptr_d;
  // memory response, registered once
  pte_u             pte_q;
  logic             rvalid_q;
  logic             accept;
  logic [LVL_W-1:0] next_lvl;

  // vpn slice that indexes the table of a level, level 0 is the root
  function automatic logic [VPN_W-1:0] vpn_slice(logic [VLEN-1:0] va, logic [LVL_W-1:0] lvl);
    int unsigned lsb;
    lsb = PAGE_OFFSET_W + VPN_W * (PT_LEVELS - 1 - int'(lvl));
    return va[lsb+:VPN_W];
  endfunction

  // misses seen while busy are dropped, the TLB repeats them
  assign accept   = (state_q == IDLE) && miss_i.access && !miss_i.hit && !flush_i;
  assign next_lvl = ctx_q.level + LVL_W'(1);

  assign miss_o         = accept;
  assign active_o       = (state_q != IDLE);
  assign mem_req_o.req  = (state_q == WAIT_GRANT);
  assign mem_req_o.addr = pptr_q;
  assign pte_o          = pte_q;
  assign ctx_o          = ctx_q;
  assign vaddr_o        = vaddr_q;

  // a flushed walk must not reach the result stage
  assign done_o  = (state_q == PTE_LOOKUP) && rvalid_q && !cls_i.fault && cls_i.leaf && !flush_i;
  assign fault_o = (state_q == PROPAGATE_ERROR) && !flush_i;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    ctx_d   = ctx_q;
    vaddr_d = vaddr_q;
    pptr_d  = pptr_q;

    case (state_q)
      IDLE: begin
        if (accept) begin
          ctx_d.is_instr  = miss_i.is_instr;
          ctx_d.is_store  = miss_i.is_store;
          ctx_d.level     = '0;
          ctx_d.is_global = 1'b0;
          ctx_d.asid      = ASID_MAX_W'(asid_i);
          vaddr_d         = miss_i.vaddr;
          // root table comes from satp
          pptr_d  = {satp_ppn_i, vpn_slice(miss_i.vaddr, '0), {PTE_BYTES_LOG2{1'b0}}};
          state_d = WAIT_GRANT;
        end
      end
      WAIT_GRANT: begin
        if (mem_rsp_i.gnt) begin
          state_d = PTE_LOOKUP;
        end
      end
      PTE_LOOKUP: begin
        if (rvalid_q) begin
          // g anywhere on the path makes the mapping global
          if (pte_q.leaf.flags.g) begin
            ctx_d.is_global = 1'b1;
          end
          if (cls_i.fault) begin
            state_d = PROPAGATE_ERROR;
          end else if (cls_i.leaf) begin
            state_d = LATENCY;
          end else begin
            // descend into the next table
            ctx_d.level = next_lvl;
            pptr_d  = {cls_i.next_ppn, vpn_slice(vaddr_q, next_lvl), {PTE_BYTES_LOG2{1'b0}}};
            state_d = WAIT_GRANT;
          end
        end
      end
      WAIT_RVALID: begin
        if (rvalid_q) begin
          state_d = IDLE;
        end
      end
      PROPAGATE_ERROR: begin
        state_d = LATENCY;
      end
      LATENCY: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // ----------------------------------------
    // flush
    // ----------------------------------------
    // a granted read still owes its rvalid, wait for it before idle
    if (flush_i) begin
      if (((state_q inside {PTE_LOOKUP, WAIT_RVALID}) && !rvalid_q) ||
          ((state_q == WAIT_GRANT) && mem_rsp_i.gnt)) begin
        state_d = WAIT_RVALID;
      end else if ((state_q != IDLE) && (state_q != LATENCY)) begin
        state_d = LATENCY;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      ctx_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      ctx_q    <= ctx_d;
      rvalid_q <= mem_rsp_i.rvalid;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q <= vaddr_d;
    pptr_q  <= pptr_d;
    pte_q   <= mem_rsp_i.rdata;
  end

endmodule

// ==== src/tlb_update_gen.sv ====
// Result stage of the Sv32 walker. Registers the TLB update entry on
// done and the page-fault pulse on fault, one cycle after either.
`timescale 1ns/100ps

module tlb_update_gen #(
  parameter int unsigned AsidWidth = 9
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          done_i,
  input  logic                          fault_i,
  input  sv32_types_pkg::ptw_ctx_t      ctx_i,
  input  sv32_types_pkg::pte_u          pte_i,
  input  logic [sv32_cfg_pkg::VLEN-1:0] vaddr_i,
  output sv32_types_pkg::tlb_update_t   update_o,
  output logic                          error_o
);

  import sv32_cfg_pkg::*;
  import sv32_types_pkg::*;

  logic                          valid_q;
  logic                          error_q;
  logic                          superpage_q;
  logic [VLEN-PAGE_OFFSET_W-1:0] vpn_q;
  logic [ASID_MAX_W-1:0]         asid_q;
  pte_u                          content_q, content_d;

  // leaf word with the g bit collected along the walk
  always_comb begin
    content_d = pte_i;
    content_d.leaf.flags.g = pte_i.leaf.flags.g | ctx_i.is_global;
  end

  // strobes follow done and fault, so each lasts one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      valid_q <= done_i;
      error_q <= fault_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_i) begin
      // leaf found at the root maps a 4 MiB superpage
      superpage_q <= (ctx_i.level == '0);
      vpn_q       <= vaddr_i[VLEN-1:PAGE_OFFSET_W];
      asid_q      <= ASID_MAX_W'(ctx_i.asid[AsidWidth-1:0]);
      content_q   <= content_d;
    end
  end

  assign update_o.valid        = valid_q;
  assign update_o.is_superpage = superpage_q;
  assign update_o.vpn          = vpn_q;
  assign update_o.asid         = asid_q;
  assign update_o.content      = content_q;
  assign error_o               = error_q;

endmodule

// ==== src/sv32_ptw.sv ====
// Sv32 hardware page-table walker. Takes TLB misses, walks the two
// table levels over a data-cache style port and returns a one-cycle
// TLB update or a one-cycle page fault.
`timescale 1ns/100ps

module sv32_ptw #(
  parameter int unsigned AsidWidth = 9
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  sv32_types_pkg::miss_req_t     miss_i,
  input  logic [sv32_cfg_pkg::PPNW-1:0] satp_ppn_i,
  input  logic [AsidWidth-1:0]          asid_i,
  input  logic                          mxr_i,
  input  sv32_types_pkg::mem_rsp_t      mem_rsp_i,
  output sv32_types_pkg::mem_req_t      mem_req_o,
  output sv32_types_pkg::tlb_update_t   tlb_update_o,
  output logic                          ptw_error_o,
  output logic                          ptw_active_o,
  output logic                          walking_instr_o,
  output logic                          tlb_miss_o,
  output logic [sv32_cfg_pkg::VLEN-1:0] update_vaddr_o
);

  import sv32_cfg_pkg::*;
  import sv32_types_pkg::*;

  // ----------------------------------------
  // stage wiring
  // ----------------------------------------
  pte_u            pte;
  ptw_ctx_t        ctx;
  pte_class_t      cls;
  logic [VLEN-1:0] vaddr;
  logic            done;
  logic            fault;

  // decode, zero cycles
  pte_decode i_pte_decode (
    .pte_i (pte),
    .ctx_i (ctx),
    .mxr_i (mxr_i),
    .cls_o (cls)
  );

  // walk control and memory requests
  walk_fsm #(
    .AsidWidth (AsidWidth)
  ) i_walk_fsm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .miss_i     (miss_i),
    .satp_ppn_i (satp_ppn_i),
    .asid_i     (asid_i),
    .mem_rsp_i  (mem_rsp_i),
    .mem_req_o  (mem_req_o),
    .cls_i      (cls),
    .pte_o      (pte),
    .ctx_o      (ctx),
    .vaddr_o    (vaddr),
    .done_o     (done),
    .fault_o    (fault),
    .active_o   (ptw_active_o),
    .miss_o     (tlb_miss_o)
  );

  // registered result
  tlb_update_gen #(
    .AsidWidth (AsidWidth)
  ) i_tlb_update_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .done_i   (done),
    .fault_i  (fault),
    .ctx_i    (ctx),
    .pte_i    (pte),
    .vaddr_i  (vaddr),
    .update_o (tlb_update_o),
    .error_o  (ptw_error_o)
  );

  assign walking_instr_o = ctx.is_instr;
  assign update_vaddr_o  = vaddr;

endmodule

// ==== tb/clk_gen.sv ====
`timescale 1ns/100ps
// Clock and reset source of the walker testbench.
// Free-running clock, active-low reset released after a fixed cycle count.

module clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release just after an edge so no flop sees it change at the edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

// ==== tb/sv32_ptw_checker.sv ====
`timescale 1ns/100ps
// Protocol assertions for the walk controller, bound into walk_fsm.
// Covers the memory request hold rule and the result strobes.

module sv32_ptw_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic flush_i,
  input logic miss_i,
  input logic req_i,
  input logic gnt_i,
  input logic done_i,
  input logic fault_i,
  input logic active_i
);

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  // request stays up until granted, a flush may abandon it
  property p_req_hold;
    @(posedge clk_i) disable iff (!rst_ni)
      req_i && !gnt_i && !flush_i |=> req_i;
  endproperty

  a_req_hold: assert property (p_req_hold)
    else $error("memory request dropped before grant");

  // idle without an accepted miss, so no fetch may follow
  property p_idle_no_req;
    @(posedge clk_i) disable iff (!rst_ni)
      !active_i && !miss_i |=> !req_i;
  endproperty

  a_idle_no_req: assert property (p_idle_no_req)
    else $error("memory request raised while idle");

  // ----------------------------------------
  // result strobes
  // ----------------------------------------
  // one strobe per walk end, never both, and none in the two cycles after
  property p_one_result;
    @(posedge clk_i) disable iff (!rst_ni)
      (done_i || fault_i) |->
        !(done_i && fault_i) ##1 !(done_i || fault_i) ##1 !(done_i || fault_i);
  endproperty

  a_one_result: assert property (p_one_result)
    else $error("done and fault not a single one-cycle result");

endmodule

bind walk_fsm sv32_ptw_checker i_sv32_ptw_checker (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .flush_i  (flush_i),
  .miss_i   (miss_o),
  .req_i    (mem_req_o.req),
  .gnt_i    (mem_rsp_i.gnt),
  .done_i   (done_o),
  .fault_i  (fault_o),
  .active_i (active_o)
);

// ==== tb/sv32_ptw_tb.sv ====
`timescale 1ns/100ps
// Testbench of the Sv32 walker. Builds random page tables per walk,
// serves them through a memory model with random grant and read delays,
// and compares each DUT result with a reference walk of the same tables.

module sv32_ptw_tb;

  import sv32_cfg_pkg::*;
  import sv32_types_pkg::*;

  localparam int unsigned AsidW      = 9;
  localparam int unsigned NumWalks   = 200;
  localparam int unsigned WalkCycles = 60;
  localparam int unsigned CycleLimit = NumWalks * WalkCycles;

  // entry bit positions as the privileged spec lists them
  localparam int BitV = 0;
  localparam int BitR = 1;
  localparam int BitW = 2;
  localparam int BitX = 3;
  localparam int BitG = 5;
  localparam int BitA = 6;
  localparam int BitD = 7;

  logic             clk;
  logic             rst_n;
  logic             flush;
  miss_req_t        miss;
  logic [PPNW-1:0]  satp_ppn;
  logic [AsidW-1:0] asid;
  logic             mxr;
  mem_rsp_t         mem_rsp;
  mem_req_t         mem_req;
  tlb_update_t      tlb_update;
  logic             ptw_error;
  logic             ptw_active;
  logic             walking_instr;
  logic             tlb_miss;
  logic [VLEN-1:0]  update_vaddr;

  logic [31:0]      pt_mem [logic [PLEN-1:0]];
  logic [31:0]      stim_rng;
  logic [31:0]      mem_rng;
  logic [PLEN-1:0]  rd_addr;
  int unsigned      gnt_wait;
  int unsigned      rv_wait;
  logic             req_seen;
  int unsigned      upd_count = 0;
  int unsigned      err_count = 0;
  int unsigned      miss_count = 0;
  int unsigned      fail_count = 0;
  int unsigned      cycle_count = 0;
  tlb_update_t      last_upd;
  logic             exp_instr;

  clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  sv32_ptw #(
    .AsidWidth (AsidW)
  ) i_sv32_ptw (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .flush_i         (flush),
    .miss_i          (miss),
    .satp_ppn_i      (satp_ppn),
    .asid_i          (asid),
    .mxr_i           (mxr),
    .mem_rsp_i       (mem_rsp),
    .mem_req_o       (mem_req),
    .tlb_update_o    (tlb_update),
    .ptw_error_o     (ptw_error),
    .ptw_active_o    (ptw_active),
    .walking_instr_o (walking_instr),
    .tlb_miss_o      (tlb_miss),
    .update_vaddr_o  (update_vaddr)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // unmapped words follow a pattern of every address bit
  function automatic logic [31:0] read_word(logic [PLEN-1:0] addr);
    if (pt_mem.exists(addr)) begin
      return pt_mem[addr];
    end
    return addr[31:0] ^ {30'h2aaa_aaaa, addr[PLEN-1:32]};
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  // grant 0..3 cycles after req, rvalid 1..4 cycles after the grant
  initial begin
    mem_rsp  = '0;
    mem_rng  = ~32'heb1;
    rd_addr  = '0;
    gnt_wait = 0;
    rv_wait  = 0;
    req_seen = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      mem_rsp.gnt    = 1'b0;
      mem_rsp.rvalid = 1'b0;
      if (rv_wait != 0) begin
        rv_wait--;
        if (rv_wait == 0) begin
          mem_rsp.rvalid = 1'b1;
          mem_rsp.rdata  = read_word(rd_addr);
        end
      end
      if (!mem_req.req) begin
        req_seen = 1'b0;
      end else if (!req_seen) begin
        mem_rng  = xorshift(mem_rng);
        gnt_wait = mem_rng % 4;
        req_seen = 1'b1;
      end
      if (req_seen) begin
        if (gnt_wait == 0) begin
          mem_rsp.gnt = 1'b1;
          rd_addr     = mem_req.addr;
          mem_rng     = xorshift(mem_rng);
          rv_wait     = 1 + mem_rng % 4;
          req_seen    = 1'b0;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  // ----------------------------------------
  // reference walk
  // ----------------------------------------
  function automatic bit perm_ok(logic [31:0] p, bit instr, bit store, bit mx);
    if (instr) begin
      return p[BitX] && p[BitA];
    end
    if (!p[BitA] || !(p[BitR] || (p[BitX] && mx))) begin
      return 1'b0;
    end
    return !store || (p[BitW] && p[BitD]);
  endfunction

  task automatic predict(input logic [VLEN-1:0] va, input bit instr, input bit store,
                         output bit fault, output bit superpage, output logic [31:0] content);
    logic [31:0]     p;
    logic [PLEN-1:0] addr;
    bit              glob;
    fault     = 1'b0;
    superpage = 1'b0;
    content   = '0;
    glob      = 1'b0;
    addr      = {satp_ppn, va[31:22], 2'b00};
    for (int lvl = 0; lvl < 2; lvl++) begin
      p    = read_word(addr);
      glob = glob | p[BitG];
      if (!p[BitV] || (p[BitW] && !p[BitR])) begin
        fault = 1'b1;
        return;
      end
      if (!p[BitR] && !p[BitX]) begin
        // pointer, only the root may hold one
        if (lvl == 1) begin
          fault = 1'b1;
          return;
        end
        addr = {p[31:10], va[21:12], 2'b00};
      end else begin
        fault         = ((lvl == 0) && (p[19:10] != '0)) || !perm_ok(p, instr, store, mxr);
        superpage     = (lvl == 0);
        content       = p;
        content[BitG] = glob;
        return;
      end
    end
  endtask

  // mostly valid and accessed entries so permissions get exercised
  function automatic logic [31:0] shape_entry(logic [31:0] w, logic [31:0] r);
    logic [31:0] s;
    s = w;
    if (r[1:0] != 2'b00) begin
      s[BitV] = 1'b1;
      s[BitA] = 1'b1;
    end
    if (r[2]) begin
      s[BitR] = 1'b1;
    end
    return s;
  endfunction

  task automatic build_tables(input logic [VLEN-1:0] va);
    logic [31:0]     p0;
    logic [31:0]     kind;
    logic [PLEN-1:0] a0;
    logic [PLEN-1:0] a1;
    pt_mem.delete();
    p0   = shape_entry(stim_rand(), stim_rand());
    kind = stim_rand() % 8;
    if (kind < 4) begin
      p0[BitR] = 1'b0;
      p0[BitW] = 1'b0;
      p0[BitX] = 1'b0;
    end else if (kind < 6) begin
      // aligned superpage candidate
      p0[19:10] = '0;
    end
    a0         = {satp_ppn, va[31:22], 2'b00};
    pt_mem[a0] = p0;
    a1         = {p0[31:10], va[21:12], 2'b00};
    pt_mem[a1] = shape_entry(stim_rand(), stim_rand());
  endtask

  // ----------------------------------------
  // monitor and timeout
  // ----------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (tlb_miss) begin
        miss_count++;
      end
      if (tlb_update.valid) begin
        upd_count++;
        last_upd = tlb_update;
      end
      if (ptw_error) begin
        err_count++;
      end
      check_eq("tlb_update_o.valid and ptw_error_o", 64'(tlb_update.valid & ptw_error), 64'd0);
      if (ptw_active) begin
        check_eq("walking_instr_o", 64'(walking_instr), 64'(exp_instr));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CycleLimit) begin
      $display("timeout: walks did not finish within %0d cycles", CycleLimit);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timeout");
    end
  end

  // ----------------------------------------
  // one walk, optionally flushed early
  // ----------------------------------------
  task automatic do_walk(input bit with_flush);
    logic [VLEN-1:0] va;
    logic [31:0]     r;
    bit              instr;
    bit              store;
    bit              exp_fault;
    bit              exp_super;
    logic [31:0]     exp_content;
    int unsigned     upd_before;
    int unsigned     err_before;
    int unsigned     gap;
    int unsigned     n;
    va    = stim_rand();
    instr = (stim_rand() % 4 == 0);
    r     = stim_rand();
    store = !instr && r[0];
    @(posedge clk);
    #2;
    r        = stim_rand();
    satp_ppn = r[PPNW-1:0];
    r        = stim_rand();
    asid     = r[AsidW-1:0];
    mxr      = r[31];
    build_tables(va);
    predict(va, instr, store, exp_fault, exp_super, exp_content);
    upd_before    = upd_count;
    err_before    = err_count;
    exp_instr     = instr;
    miss.access   = 1'b1;
    miss.hit      = 1'b0;
    miss.is_instr = instr;
    miss.is_store = store;
    miss.vaddr    = va;
    @(negedge clk);
    check_eq("tlb_miss_o", 64'(tlb_miss), 64'd1);
    @(posedge clk);
    #2;
    // miss stays up one more cycle while busy, it must not be taken again
    check_eq("mem_req_o.req after accept", 64'(mem_req.req), 64'd1);
    if (with_flush) begin
      // early enough that no result can be on its way yet
      gap = stim_rand() % 3;
      repeat (gap) begin
        @(posedge clk);
        #2;
        miss.access = 1'b0;
      end
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush       = 1'b0;
      miss.access = 1'b0;
      n = 0;
      while (ptw_active && (n < 10)) begin
        @(posedge clk);
        #2;
        n++;
      end
      check_eq("ptw_active_o after flush", 64'(ptw_active), 64'd0);
      @(posedge clk);
      #2;
      check_eq("update count after flush", 64'(upd_count - upd_before), 64'd0);
      check_eq("error count after flush", 64'(err_count - err_before), 64'd0);
    end else begin
      @(posedge clk);
      #2;
      miss.access = 1'b0;
      while (ptw_active) begin
        @(posedge clk);
        #2;
      end
      check_eq("update_vaddr_o", 64'(update_vaddr), 64'(va));
      check_eq("ptw_error_o pulses", 64'(err_count - err_before), 64'(exp_fault));
      check_eq("tlb_update_o.valid pulses", 64'(upd_count - upd_before), 64'(!exp_fault));
      if (!exp_fault) begin
        check_eq("tlb_update_o.is_superpage", 64'(last_upd.is_superpage), 64'(exp_super));
        check_eq("tlb_update_o.vpn", 64'(last_upd.vpn), 64'(va[31:12]));
        check_eq("tlb_update_o.asid", 64'(last_upd.asid), 64'(asid));
        check_eq("tlb_update_o.content", 64'(last_upd.content), 64'(exp_content));
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    flush     = 1'b0;
    miss      = '0;
    satp_ppn  = '0;
    asid      = '0;
    mxr       = 1'b0;
    exp_instr = 1'b0;
    stim_rng  = 32'heb1;
    @(posedge rst_n);
    @(negedge clk);
    check_eq("mem_req_o.req after reset", 64'(mem_req.req), 64'd0);
    check_eq("tlb_update_o.valid after reset", 64'(tlb_update.valid), 64'd0);
    check_eq("ptw_error_o after reset", 64'(ptw_error), 64'd0);
    check_eq("tlb_miss_o after reset", 64'(tlb_miss), 64'd0);
    check_eq("ptw_active_o after reset", 64'(ptw_active), 64'd0);
    for (int w = 0; w < NumWalks; w++) begin
      do_walk(stim_rand() % 6 == 0);
    end
    @(posedge clk);
    #2;
    check_eq("tlb_miss_o pulse count", 64'(miss_count), 64'(NumWalks));
    if (fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "checks failed");
    end
  end

endmodule

// ==== sv32_ptw.f ====
src/sv32_cfg_pkg.sv
src/sv32_types_pkg.sv
src/pte_decode.sv
src/walk_fsm.sv
src/tlb_update_gen.sv
src/sv32_ptw.sv
tb/clk_gen.sv
tb/sv32_ptw_checker.sv
tb/sv32_ptw_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the walker testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module sv32_ptw_tb -f sv32_ptw.f

./obj_dir/Vsv32_ptw_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a pass line"
  exit 1
fi
